/* sim.f */
src/ad9866_pkg.sv
src/ad9866_tx_serializer.sv
src/ad9866_rx_assembler.sv
src/ad9866_level_monitor.sv
src/ad9866_gain_regs.sv
src/ad9866_if.sv
verification/ad9866_chk.sv
verification/ad9866_tb.sv

/* src/ad9866_gain_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module ad9866_gain_regs (
  input  wire                   clk,
  input  wire                   rxclrstatus,
  input  wire ad9866_pkg::cmd_addr_t cmd_addr,
  input  wire ad9866_pkg::cmd_data_t cmd_data,
  input  wire                   cmd_rqst,
  output logic                  cmd_ack,
  output ad9866_pkg::gain_t     gain
);

  import ad9866_pkg::*;

  logic cmd_rqst_d;
  logic gain_wr;

  // Translate the written value into a PGA code
  function automatic gain_t map_gain(input cmd_data_t data);
    gain_t code;
    if (data[6]) begin
      code = data[5:0];
    end else if (data[5]) begin
      code = ~data[5:0];
    end else begin
      code = {1'b1, data[4:0]};
    end
    return code;
  endfunction

  // Only the first cycle of a request writes
  assign gain_wr = cmd_rqst && !cmd_rqst_d && (cmd_addr == GAIN_ADDR);

  always_ff @(posedge clk) begin
    if (rxclrstatus) begin
      cmd_rqst_d <= 1'b0;
      cmd_ack    <= 1'b0;
      gain       <= GAIN_DEFAULT;
    end else begin
      cmd_rqst_d <= cmd_rqst;
      // Ack is one cycle wide, one cycle after the write
      cmd_ack    <= gain_wr;
      if (gain_wr) begin
        gain <= map_gain(cmd_data);
      end
    end
  end

endmodule

`default_nettype wire

/* src/ad9866_if.sv */
`timescale 1ns/10ps
`default_nettype none

module ad9866_if (
  input  wire                   clk,
  input  wire                   clk_2x,
  input  wire                   rxclrstatus,
  // User side
  input  wire ad9866_pkg::sample_t   tx_data,
  input  wire                   tx_en,
  output ad9866_pkg::sample_t   rx_data,
  output logic                  rxclip,
  output logic                  rxgoodlvl,
  // Command slave
  input  wire ad9866_pkg::cmd_addr_t cmd_addr,
  input  wire ad9866_pkg::cmd_data_t cmd_data,
  input  wire                   cmd_rqst,
  output logic                  cmd_ack,
  // Converter pins
  output ad9866_pkg::nibble_t   ad_tx,
  output logic                  ad_txsync,
  output logic                  ad_txquiet_n,
  output logic                  ad_pga5,
  input  wire ad9866_pkg::nibble_t   ad_rx,
  input  wire                   ad_rxsync,
  output logic                  ad_mode
);

  import ad9866_pkg::*;

  gain_t gain;

  // Full duplex only
  assign ad_mode = 1'b1;

  ad9866_tx_serializer i_tx_ser (
    .clk_2x       (clk_2x),
    .rxclrstatus  (rxclrstatus),
    .tx_data      (tx_data),
    .tx_en        (tx_en),
    .gain         (gain),
    .ad_tx        (ad_tx),
    .ad_txsync    (ad_txsync),
    .ad_txquiet_n (ad_txquiet_n),
    .ad_pga5      (ad_pga5)
  );

  ad9866_rx_assembler i_rx_asm (
    .clk         (clk),
    .clk_2x      (clk_2x),
    .rxclrstatus (rxclrstatus),
    .ad_rx       (ad_rx),
    .ad_rxsync   (ad_rxsync),
    .rx_data     (rx_data)
  );

  ad9866_level_monitor i_level (
    .clk         (clk),
    .rxclrstatus (rxclrstatus),
    .rx_data     (rx_data),
    .rxclip      (rxclip),
    .rxgoodlvl   (rxgoodlvl)
  );

  ad9866_gain_regs i_gain (
    .clk         (clk),
    .rxclrstatus (rxclrstatus),
    .cmd_addr    (cmd_addr),
    .cmd_data    (cmd_data),
    .cmd_rqst    (cmd_rqst),
    .cmd_ack     (cmd_ack),
    .gain        (gain)
  );

endmodule

`default_nettype wire

/* src/ad9866_level_monitor.sv */
`timescale 1ns/10ps
`default_nettype none

module ad9866_level_monitor (
  input  wire                 clk,
  input  wire                 rxclrstatus,
  input  wire ad9866_pkg::sample_t rx_data,
  output logic                rxclip,
  output logic                rxgoodlvl
);

  import ad9866_pkg::*;

  logic clip_hit;
  logic good_hit;
  logic [2:0] rx_top;

  assign rx_top = rx_data[SAMPLE_W-1:SAMPLE_W-3];

  // Either rail counts as a clip
  assign clip_hit = (rx_data == CLIP_POS) || (rx_data == CLIP_NEG);

  // Three quarters of full scale or more, either polarity
  assign good_hit = (rx_top == GOOD_POS_TOP) || (rx_top == GOOD_NEG_TOP);

  // Sticky flags, a hit in the clear cycle still sets
  always_ff @(posedge clk) begin
    if (rxclrstatus) begin
      rxclip <= 1'b0;
    end
    if (clip_hit) begin
      rxclip <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rxclrstatus) begin
      rxgoodlvl <= 1'b0;
    end
    if (good_hit) begin
      rxgoodlvl <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* src/ad9866_pkg.sv */
`default_nettype none

package ad9866_pkg;

  // Widths on the converter side
  localparam int SAMPLE_W = 12;
  localparam int NIBBLE_W = 6;
  localparam int GAIN_W   = 6;

  // Widths on the command bus
  localparam int CMD_ADDR_W = 6;
  localparam int CMD_DATA_W = 32;

  typedef logic [SAMPLE_W-1:0]   sample_t;
  typedef logic [NIBBLE_W-1:0]   nibble_t;
  typedef logic [GAIN_W-1:0]     gain_t;
  typedef logic [CMD_ADDR_W-1:0] cmd_addr_t;
  typedef logic [CMD_DATA_W-1:0] cmd_data_t;

  // Which half of the sample goes out on the next clk_2x cycle
  typedef enum logic {
    PHASE_HIGH,
    PHASE_LOW
  } tx_phase_e;

  // Receive gain register
  localparam cmd_addr_t GAIN_ADDR    = 6'h0a;
  localparam gain_t     GAIN_DEFAULT = 6'h1f;

  // Full scale, two's complement
  localparam sample_t CLIP_POS = 12'b0111_1111_1111;
  localparam sample_t CLIP_NEG = 12'b1000_0000_0000;

  // Top three bits of a sample near three quarters of full scale
  localparam logic [2:0] GOOD_POS_TOP = 3'b011;
  localparam logic [2:0] GOOD_NEG_TOP = 3'b100;

endpackage

`default_nettype wire

/* src/ad9866_rx_assembler.sv */
`timescale 1ns/10ps
`default_nettype none

module ad9866_rx_assembler (
  input  wire                 clk,
  input  wire                 clk_2x,
  input  wire                 rxclrstatus,
  input  wire ad9866_pkg::nibble_t ad_rx,
  input  wire                 ad_rxsync,
  output ad9866_pkg::sample_t rx_data
);

  import ad9866_pkg::*;

  nibble_t rx_d1;
  nibble_t rx_d2;
  logic    rxsync_d1;
  sample_t rx_assembled;

  // Two deep nibble pipeline, high nibble ends up in rx_d2
  always_ff @(posedge clk_2x) begin
    if (rxclrstatus) begin
      rx_d1 <= '0;
      rx_d2 <= '0;
    end else begin
      rx_d1 <= ad_rx;
      rx_d2 <= rx_d1;
    end
  end

  // Sync marks the low nibble, so the pair is complete one cycle later
  always_ff @(posedge clk_2x) begin
    if (rxclrstatus) begin
      rxsync_d1    <= 1'b0;
      rx_assembled <= '0;
    end else begin
      rxsync_d1 <= ad_rxsync;
      if (rxsync_d1) begin
        rx_assembled <= {rx_d2, rx_d1};
      end
    end
  end

  // Retime to clk; clk_2x is phase aligned so a plain register is enough
  always_ff @(posedge clk) begin
    if (rxclrstatus) begin
      rx_data <= '0;
    end else begin
      rx_data <= rx_assembled;
    end
  end

endmodule

`default_nettype wire

/* src/ad9866_tx_serializer.sv */
`timescale 1ns/10ps
`default_nettype none

module ad9866_tx_serializer (
  input  wire                 clk_2x,
  input  wire                 rxclrstatus,
  input  wire ad9866_pkg::sample_t tx_data,
  input  wire                 tx_en,
  input  wire ad9866_pkg::gain_t   gain,
  output ad9866_pkg::nibble_t ad_tx,
  output logic                ad_txsync,
  output logic                ad_txquiet_n,
  output logic                ad_pga5
);

  import ad9866_pkg::*;

  logic      tx_en_d;
  tx_phase_e phase;
  sample_t   tx_sample;

  // Enable pipeline and nibble phase
  // All pin controls come out of the same register stage as ad_tx
  always_ff @(posedge clk_2x) begin
    if (rxclrstatus) begin
      tx_en_d      <= 1'b0;
      phase        <= PHASE_HIGH;
      ad_txsync    <= 1'b0;
      ad_txquiet_n <= 1'b0;
      ad_pga5      <= 1'b1;
    end else begin
      tx_en_d      <= tx_en;
      ad_txquiet_n <= tx_en_d;
      // Fast LNA on the PGA pin only while the transmitter is quiet
      ad_pga5      <= ~tx_en_d;
      if (tx_en_d) begin
        phase     <= (phase == PHASE_HIGH) ? PHASE_LOW : PHASE_HIGH;
        ad_txsync <= (phase == PHASE_LOW);
      end else begin
        // Start every burst with a high nibble
        phase     <= PHASE_HIGH;
        ad_txsync <= 1'b0;
      end
    end
  end

  // Sample capture
  // While idle the register follows tx_data so the first burst sample is ready
  always_ff @(posedge clk_2x) begin
    if (rxclrstatus) begin
      tx_sample <= '0;
    end else if (!tx_en_d || (phase == PHASE_LOW)) begin
      tx_sample <= tx_data;
    end
  end

  // Pin data: high nibble, low nibble, or the gain code when idle
  always_ff @(posedge clk_2x) begin
    if (rxclrstatus) begin
      ad_tx <= GAIN_DEFAULT;
    end else if (!tx_en_d) begin
      ad_tx <= gain;
    end else if (phase == PHASE_HIGH) begin
      ad_tx <= tx_sample[SAMPLE_W-1:NIBBLE_W];
    end else begin
      ad_tx <= tx_sample[NIBBLE_W-1:0];
    end
  end

endmodule

`default_nettype wire

/* verification/ad9866_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module ad9866_chk (
  input wire clk,
  input wire clk_2x,
  input wire rxclrstatus,
  input wire tx_en,
  input wire ad_txsync,
  input wire ad_txquiet_n,
  input wire ad_pga5,
  input wire cmd_rqst,
  input wire cmd_ack
);

  // The low nibble marker only shows up inside a burst, right after a high nibble
  a_sync_in_burst: assert property (@(posedge clk_2x) disable iff (rxclrstatus)
    ad_txsync |-> ad_txquiet_n && $past(ad_txquiet_n) && !$past(ad_txsync))
    else $error("ad_txsync high outside a burst or without a high nibble before it");

  // Quiet and fast LNA pins follow tx_en one clk cycle later, in opposite senses
  a_pga5_inverse: assert property (@(posedge clk_2x) disable iff (rxclrstatus)
    (ad_txquiet_n == $past(tx_en, 2)) && (ad_pga5 == !$past(tx_en, 2)))
    else $error("ad_txquiet_n or ad_pga5 does not follow tx_en");

  a_ack_single: assert property (@(posedge clk) disable iff (rxclrstatus)
    cmd_ack |=> !cmd_ack)
    else $error("cmd_ack held for two cycles");

  // An ack answers the first cycle of a request
  a_ack_after_rqst: assert property (@(posedge clk) disable iff (rxclrstatus)
    cmd_ack |-> $past(cmd_rqst) && !$past(cmd_rqst, 2))
    else $error("cmd_ack not one cycle after the start of a request");

endmodule

`default_nettype wire

/* verification/ad9866_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module ad9866_tb;

  import ad9866_pkg::*;

  localparam int N_TX = 12;
  localparam int N_RX = 16;
  // Clock cycles per test, used by the watchdog
  localparam int TIMEOUT_CYCLES = 5 + (N_TX * 4 + 10) + (N_RX * 8) + 60 + 80 + 200;

  logic      clk;
  logic      clk_2x;
  logic      rxclrstatus;
  sample_t   tx_data;
  logic      tx_en;
  sample_t   rx_data;
  logic      rxclip;
  logic      rxgoodlvl;
  cmd_addr_t cmd_addr;
  cmd_data_t cmd_data;
  logic      cmd_rqst;
  logic      cmd_ack;
  nibble_t   ad_tx;
  logic      ad_txsync;
  logic      ad_txquiet_n;
  logic      ad_pga5;
  nibble_t   ad_rx;
  logic      ad_rxsync;
  logic      ad_mode;

  logic      tx_capture;
  nibble_t   prev_nib;
  sample_t   tx_words[$];

  ad9866_if i_dut (.*);

  bind ad9866_if ad9866_chk i_chk (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // First rising edge at 4 ns, together with the first rising edge of clk
  initial begin
    clk_2x = 1'b0;
    #2;
    forever #2 clk_2x = ~clk_2x;
  end

  // Rebuild transmitted words from the pins, between clk_2x edges
  always @(negedge clk_2x) begin
    if (tx_capture && ad_txsync) begin
      tx_words.push_back({prev_nib, ad_tx});
    end
    prev_nib <= ad_tx;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_sample(input string test, input sample_t exp, input sample_t act);
    if (act !== exp) begin
      stop_run($sformatf("** Error [%s] expected %h actual %h", test, exp, act));
    end
  endtask

  task automatic check_gain(input string test, input gain_t exp, input gain_t act);
    if (act !== exp) begin
      stop_run($sformatf("** Error [%s] expected %h actual %h", test, exp, act));
    end
  endtask

  task automatic check_flag(input string test, input logic exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("** Error [%s] expected %b actual %b", test, exp, act));
    end
  endtask

  task automatic pulse_clear();
    @(posedge clk);
    #1 rxclrstatus = 1'b1;
    @(posedge clk);
    #1 rxclrstatus = 1'b0;
  endtask

  // Converter model: high nibble with sync low, then low nibble with sync high
  task automatic send_rx_sample(input sample_t s);
    @(posedge clk_2x);
    #1 ad_rx = s[11:6];
    ad_rxsync = 1'b0;
    @(posedge clk_2x);
    #1 ad_rx = s[5:0];
    ad_rxsync = 1'b1;
    @(posedge clk_2x);
    #1 ad_rxsync = 1'b0;
  endtask

  task automatic rx_roundtrip(input string test, input sample_t s);
    int n;
    n = 0;
    send_rx_sample(s);
    do begin
      @(negedge clk);
      n++;
    end while (rx_data !== s && n < 3);
    check_sample(test, s, rx_data);
  endtask

  task automatic test_reset_state();
    repeat (2) @(negedge clk);
    check_flag("reset rxclip", 1'b0, rxclip);
    check_flag("reset rxgoodlvl", 1'b0, rxgoodlvl);
    check_flag("reset cmd_ack", 1'b0, cmd_ack);
    check_flag("reset ad_mode", 1'b1, ad_mode);
    @(negedge clk_2x);
    check_flag("reset ad_pga5", 1'b1, ad_pga5);
    check_flag("reset ad_txsync", 1'b0, ad_txsync);
    check_flag("reset ad_txquiet_n", 1'b0, ad_txquiet_n);
    check_gain("reset idle gain", GAIN_DEFAULT, ad_tx);
  endtask

  task automatic test_tx_serializer();
    sample_t sent[$];
    sample_t uniq[$];
    sample_t s;
    s = '0;
    tx_words.delete();
    tx_capture = 1'b1;
    for (int i = 0; i < N_TX; i++) begin
      // Neighbours differ so each hold shows up as its own run
      do s = sample_t'($urandom); while (sent.size() > 0 && s == sent[$]);
      sent.push_back(s);
      @(posedge clk);
      #1 tx_data = s;
      tx_en = 1'b1;
      repeat (3) @(posedge clk);
    end
    @(posedge clk);
    #1 tx_en = 1'b0;
    repeat (4) @(posedge clk);
    tx_capture = 1'b0;
    foreach (tx_words[i]) begin
      if (uniq.size() == 0 || tx_words[i] != uniq[$]) begin
        uniq.push_back(tx_words[i]);
      end
    end
    if (uniq.size() != sent.size()) begin
      stop_run($sformatf("Transmit produced %0d distinct words for %0d samples",
                         uniq.size(), sent.size()));
    end
    foreach (sent[i]) begin
      check_sample("tx serializing", sent[i], uniq[i]);
    end
  endtask

  task automatic test_rx_assembly();
    for (int i = 0; i < N_RX; i++) begin
      rx_roundtrip("rx assembly", sample_t'($urandom));
    end
  endtask

  task automatic test_level_flags();
    pulse_clear();
    rx_roundtrip("level mid", 12'h100);
    repeat (2) @(negedge clk);
    check_flag("mid rxclip", 1'b0, rxclip);
    check_flag("mid rxgoodlvl", 1'b0, rxgoodlvl);
    rx_roundtrip("level good", 12'h6a5);
    repeat (2) @(negedge clk);
    check_flag("good rxclip", 1'b0, rxclip);
    check_flag("good rxgoodlvl", 1'b1, rxgoodlvl);
    rx_roundtrip("level clip", CLIP_NEG);
    repeat (2) @(negedge clk);
    check_flag("clip rxclip", 1'b1, rxclip);
    // Move off the rail first, otherwise the set would win over the clear
    rx_roundtrip("level back to mid", 12'h100);
    pulse_clear();
    repeat (2) @(negedge clk);
    check_flag("cleared rxclip", 1'b0, rxclip);
    check_flag("cleared rxgoodlvl", 1'b0, rxgoodlvl);
  endtask

  task automatic write_gain(input string test, input cmd_data_t data, input gain_t exp);
    int n;
    n = 0;
    @(posedge clk);
    #1 cmd_addr = GAIN_ADDR;
    cmd_data = data;
    cmd_rqst = 1'b1;
    do begin
      @(negedge clk);
      n++;
    end while (!cmd_ack && n < 8);
    if (!cmd_ack) begin
      stop_run($sformatf("No acknowledge for the gain write in test %s", test));
    end
    @(posedge clk);
    #1 cmd_rqst = 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_flag({test, " single ack"}, 1'b0, cmd_ack);
    end
    @(negedge clk_2x);
    check_gain(test, exp, ad_tx);
  endtask

  task automatic test_gain_command();
    // Expected codes worked out by hand from the mapping rule
    write_gain("gain bit6", 32'h0000_0055, 6'h15);
    write_gain("gain bit5", 32'h0000_0029, 6'h16);
    write_gain("gain plain", 32'h0000_000c, 6'h2c);
    @(posedge clk);
    #1 cmd_addr = 6'h0b;
    cmd_data = 32'h0000_0041;
    cmd_rqst = 1'b1;
    repeat (8) begin
      @(negedge clk);
      check_flag("foreign address ack", 1'b0, cmd_ack);
    end
    @(posedge clk);
    #1 cmd_rqst = 1'b0;
    repeat (2) @(negedge clk);
    @(negedge clk_2x);
    check_gain("foreign address gain", 6'h2c, ad_tx);
  endtask

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    stop_run("Timeout: the tests did not finish in time");
  end

  initial begin
    void'($urandom(32'h27e5_893d));
    rxclrstatus = 1'b1;
    tx_data = '0;
    tx_en = 1'b0;
    cmd_addr = '0;
    cmd_data = '0;
    cmd_rqst = 1'b0;
    ad_rx = '0;
    ad_rxsync = 1'b0;
    tx_capture = 1'b0;
    prev_nib = '0;
    repeat (3) @(posedge clk);
    #1 rxclrstatus = 1'b0;
    test_reset_state();
    test_tx_serializer();
    test_rx_assembly();
    test_level_flags();
    test_gain_command();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
